// ==== rtl/mem_ctrl_pkg.sv ====
package mem_ctrl_pkg;

  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;

  // word addressed, low two address bits dropped
  localparam int RAM_DEPTH = 256;
  localparam int RAM_AW = $clog2(RAM_DEPTH);

  // busy cycles before access
  localparam int RAM_LAT = 2;
  localparam int LAT_W = $clog2(RAM_LAT + 1);
  localparam logic [LAT_W-1:0] LAT_LOAD = LAT_W'(RAM_LAT - 1);

  typedef enum logic [1:0] {
    FREE,
    BUSY,
    ACCESS,
    ERROR
  } ramstate_t;

  typedef enum logic [3:0] {
    IDLE,
    ARBITER,
    SNOOP,
    WRITE_BACK_0,
    WRITE_BACK_1,
    FETCH_CACHE_0,
    FETCH_CACHE_1,
    MISS_0,
    MISS_1,
    EVICTION,
    HALT
  } cc_state_t;

endpackage

// ==== rtl/coherence_fsm.sv ====
`timescale 1ns/1ps

module coherence_fsm (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic [1:0]                halted,
  input  logic [1:0]                flushed,
  input  logic [1:0]                evict,
  input  logic [1:0]                dREN,
  input  logic [1:0]                dWEN,
  input  logic [1:0]                iREN,
  input  mem_ctrl_pkg::word_t       daddr [2],
  input  logic [1:0]                cctrans,
  input  logic [1:0]                ccwrite,
  input  logic [1:0]                dwait,
  output logic                      active,
  output logic                      active_core,
  output logic                      ccdataready,
  output logic                      ccmemtransfer,
  output mem_ctrl_pkg::cc_state_t   cc_state,
  output logic [1:0]                ccwait,
  output mem_ctrl_pkg::word_t       ccsnoopaddr [2],
  output logic [1:0]                ccinv
);

  mem_ctrl_pkg::cc_state_t state;
  mem_ctrl_pkg::cc_state_t next_state;
  mem_ctrl_pkg::cc_state_t snoop_choice;
  logic                    next_core;
  logic                    peer;
  logic [1:0]              dreq;
  logic                    peer_hold;
  logic                    in_xact;

  // halted cores no longer compete for the bus
  assign dreq = (dREN | dWEN) & ~halted;
  assign peer = ~active_core;

  // path once the peer has answered the snoop
  always_comb begin
    if (halted[peer] || !cctrans[peer]) begin
      snoop_choice = mem_ctrl_pkg::MISS_0;
    end else if (ccwrite[peer]) begin
      snoop_choice = mem_ctrl_pkg::WRITE_BACK_0;
    end else begin
      snoop_choice = mem_ctrl_pkg::FETCH_CACHE_0;
    end
  end

  always_comb begin
    next_state = state;
    next_core  = active_core;

    case (state)
      mem_ctrl_pkg::IDLE: begin
        if (halted[0] && !flushed[0]) begin
          next_state = mem_ctrl_pkg::HALT;
          next_core  = 1'b0;
        end else if (halted[1] && !flushed[1]) begin
          next_state = mem_ctrl_pkg::HALT;
          next_core  = 1'b1;
        end else if (|dreq) begin
          next_state = mem_ctrl_pkg::ARBITER;
        end else if (!iREN[active_core] && iREN[peer]) begin
          // fetch ownership moves only when the owner is quiet
          next_core = peer;
        end
      end

      mem_ctrl_pkg::ARBITER: begin
        if (dreq[0]) begin
          next_core  = 1'b0;
          next_state = mem_ctrl_pkg::SNOOP;
        end else if (dreq[1]) begin
          next_core  = 1'b1;
          next_state = mem_ctrl_pkg::SNOOP;
        end else begin
          next_state = mem_ctrl_pkg::IDLE;
        end
      end

      mem_ctrl_pkg::SNOOP: begin
        if (evict[active_core]) begin
          next_state = mem_ctrl_pkg::EVICTION;
        end else begin
          next_state = snoop_choice;
        end
      end

      // victim goes out first, then the snoop result is taken again
      mem_ctrl_pkg::EVICTION: begin
        if (!evict[active_core]) begin
          next_state = snoop_choice;
        end
      end

      mem_ctrl_pkg::WRITE_BACK_0: begin
        if (!dwait[active_core]) begin
          next_state = mem_ctrl_pkg::WRITE_BACK_1;
        end
      end

      mem_ctrl_pkg::WRITE_BACK_1: begin
        next_state = mem_ctrl_pkg::IDLE;
      end

      mem_ctrl_pkg::FETCH_CACHE_0: begin
        next_state = mem_ctrl_pkg::FETCH_CACHE_1;
      end

      mem_ctrl_pkg::FETCH_CACHE_1: begin
        next_state = mem_ctrl_pkg::IDLE;
      end

      mem_ctrl_pkg::MISS_0: begin
        if (!dwait[active_core]) begin
          next_state = mem_ctrl_pkg::MISS_1;
        end
      end

      mem_ctrl_pkg::MISS_1: begin
        next_state = mem_ctrl_pkg::IDLE;
      end

      mem_ctrl_pkg::HALT: begin
        if (flushed[active_core]) begin
          next_state = mem_ctrl_pkg::IDLE;
        end
      end

      default: begin
        next_state = mem_ctrl_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state       <= mem_ctrl_pkg::IDLE;
      active_core <= 1'b0;
    end else begin
      state       <= next_state;
      active_core <= next_core;
    end
  end

  // data ownership of the bus
  assign active = state inside {mem_ctrl_pkg::WRITE_BACK_0, mem_ctrl_pkg::FETCH_CACHE_0,
                                mem_ctrl_pkg::FETCH_CACHE_1, mem_ctrl_pkg::MISS_0,
                                mem_ctrl_pkg::EVICTION, mem_ctrl_pkg::HALT};

  assign ccdataready   = (state == mem_ctrl_pkg::FETCH_CACHE_1);
  assign ccmemtransfer = (state == mem_ctrl_pkg::WRITE_BACK_0);
  assign cc_state      = state;

  // peer holds its line and data while it is being snooped
  assign peer_hold = !halted[peer] &&
                     (state inside {mem_ctrl_pkg::SNOOP, mem_ctrl_pkg::EVICTION,
                                    mem_ctrl_pkg::WRITE_BACK_0, mem_ctrl_pkg::WRITE_BACK_1,
                                    mem_ctrl_pkg::FETCH_CACHE_0, mem_ctrl_pkg::FETCH_CACHE_1});

  assign in_xact = state inside {mem_ctrl_pkg::SNOOP, mem_ctrl_pkg::WRITE_BACK_0,
                                 mem_ctrl_pkg::WRITE_BACK_1, mem_ctrl_pkg::FETCH_CACHE_0,
                                 mem_ctrl_pkg::FETCH_CACHE_1, mem_ctrl_pkg::MISS_0,
                                 mem_ctrl_pkg::MISS_1};

  always_comb begin
    ccwait         = '0;
    ccinv          = '0;
    ccsnoopaddr[0] = '0;
    ccsnoopaddr[1] = '0;
    if (peer_hold) begin
      ccwait[peer]      = 1'b1;
      ccsnoopaddr[peer] = daddr[active_core];
    end
    // a write by the owner kills the other copy
    if (in_xact && dWEN[active_core]) begin
      ccinv[peer] = 1'b1;
    end
  end

endmodule

// ==== rtl/ram_model.sv ====
`timescale 1ns/1ps

module ram_model (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      ramREN,
  input  logic                      ramWEN,
  input  mem_ctrl_pkg::word_t       ramaddr,
  input  mem_ctrl_pkg::word_t       ramstore,
  output mem_ctrl_pkg::word_t       ramload,
  output mem_ctrl_pkg::ramstate_t   ramstate
);

  mem_ctrl_pkg::word_t                mem [mem_ctrl_pkg::RAM_DEPTH];
  mem_ctrl_pkg::ramstate_t            state;
  logic [mem_ctrl_pkg::LAT_W-1:0]     count;
  mem_ctrl_pkg::word_t                held_addr;
  logic                               held_wen;
  logic                               req;
  logic                               same;
  logic [mem_ctrl_pkg::RAM_AW-1:0]    index;

  assign req     = ramREN | ramWEN;
  assign same    = (ramaddr == held_addr) && (ramWEN == held_wen);
  assign index   = ramaddr[mem_ctrl_pkg::RAM_AW+1:2];
  assign ramload = mem[index];

  // an access finished for some other request is still busy for this one
  assign ramstate = (state == mem_ctrl_pkg::ACCESS && !same) ? mem_ctrl_pkg::BUSY : state;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state     <= mem_ctrl_pkg::FREE;
      count     <= '0;
      held_addr <= '0;
      held_wen  <= 1'b0;
      for (int i = 0; i < mem_ctrl_pkg::RAM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (state == mem_ctrl_pkg::ACCESS && same && held_wen) begin
        mem[index] <= ramstore;
      end

      if (!req) begin
        state <= mem_ctrl_pkg::FREE;
      end else if (state == mem_ctrl_pkg::FREE || !same) begin
        // accept, or restart on a changed request
        state     <= mem_ctrl_pkg::BUSY;
        count     <= mem_ctrl_pkg::LAT_LOAD;
        held_addr <= ramaddr;
        held_wen  <= ramWEN;
      end else if (state == mem_ctrl_pkg::BUSY) begin
        if (count == '0) begin
          state <= mem_ctrl_pkg::ACCESS;
        end else begin
          count <= count - 1'b1;
        end
      end else begin
        state <= mem_ctrl_pkg::FREE;
      end
    end
  end

endmodule

// ==== rtl/bus_router.sv ====
`timescale 1ns/1ps

module bus_router (
  input  logic                      active,
  input  logic                      active_core,
  input  logic                      ccdataready,
  input  logic                      ccmemtransfer,
  input  mem_ctrl_pkg::cc_state_t   cc_state,
  input  logic [1:0]                dREN,
  input  logic [1:0]                dWEN,
  input  logic [1:0]                iREN,
  input  mem_ctrl_pkg::word_t       daddr [2],
  input  mem_ctrl_pkg::word_t       iaddr [2],
  input  mem_ctrl_pkg::word_t       dstore [2],
  input  mem_ctrl_pkg::word_t       ramload,
  input  mem_ctrl_pkg::ramstate_t   ramstate,
  output logic [1:0]                iwait,
  output logic [1:0]                dwait,
  output mem_ctrl_pkg::word_t       iload [2],
  output mem_ctrl_pkg::word_t       dload [2],
  output logic                      ramREN,
  output logic                      ramWEN,
  output mem_ctrl_pkg::word_t       ramaddr,
  output mem_ctrl_pkg::word_t       ramstore
);

  logic peer;
  logic fetch_core;
  logic data_req;
  logic ram_phase;
  logic ram_ready;

  assign peer      = ~active_core;
  assign data_req  = dREN[active_core] | dWEN[active_core];
  assign ram_ready = (ramstate == mem_ctrl_pkg::ACCESS);

  // states in which the owner's data request may use the RAM
  assign ram_phase = cc_state inside {mem_ctrl_pkg::MISS_0, mem_ctrl_pkg::WRITE_BACK_0,
                                      mem_ctrl_pkg::EVICTION, mem_ctrl_pkg::HALT};

  // same ownership rule the FSM applies in IDLE, without its cycle of delay
  assign fetch_core = iREN[active_core] ? active_core : peer;

  always_comb begin
    iwait    = '1;
    dwait    = '1;
    iload[0] = ramload;
    iload[1] = ramload;
    dload[0] = ramload;
    dload[1] = ramload;
    ramREN   = 1'b0;
    ramWEN   = 1'b0;
    ramaddr  = '0;
    ramstore = '0;

    if (active) begin
      if (ccdataready && data_req) begin
        // cache to cache, RAM untouched
        dload[active_core] = dstore[peer];
        dwait[active_core] = 1'b0;
      end else if (ram_phase && data_req) begin
        ramaddr = daddr[active_core];
        if (ccmemtransfer) begin
          // modified peer word goes to RAM and to the requester
          ramWEN             = 1'b1;
          ramstore           = dstore[peer];
          dload[active_core] = dstore[peer];
        end else begin
          ramREN   = dREN[active_core];
          ramWEN   = ~dREN[active_core];
          ramstore = dstore[active_core];
        end
        dwait[active_core] = ~ram_ready;
      end
    end else if (iREN[fetch_core]) begin
      ramREN            = 1'b1;
      ramaddr           = iaddr[fetch_core];
      iwait[fetch_core] = ~ram_ready;
    end
  end

endmodule

// ==== rtl/coherent_mem_sys.sv ====
`timescale 1ns/1ps

module coherent_mem_sys (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic [1:0]            iREN,
  input  mem_ctrl_pkg::word_t   iaddr [2],
  input  logic [1:0]            dREN,
  input  logic [1:0]            dWEN,
  input  mem_ctrl_pkg::word_t   daddr [2],
  input  mem_ctrl_pkg::word_t   dstore [2],
  input  logic [1:0]            cctrans,
  input  logic [1:0]            ccwrite,
  input  logic [1:0]            halted,
  input  logic [1:0]            flushed,
  input  logic [1:0]            evict,
  output logic [1:0]            iwait,
  output logic [1:0]            dwait,
  output mem_ctrl_pkg::word_t   iload [2],
  output mem_ctrl_pkg::word_t   dload [2],
  output logic [1:0]            ccwait,
  output mem_ctrl_pkg::word_t   ccsnoopaddr [2],
  output logic [1:0]            ccinv
);

  logic                       active;
  logic                       active_core;
  logic                       ccdataready;
  logic                       ccmemtransfer;
  mem_ctrl_pkg::cc_state_t    cc_state;

  logic                       ramREN;
  logic                       ramWEN;
  mem_ctrl_pkg::word_t        ramaddr;
  mem_ctrl_pkg::word_t        ramstore;
  mem_ctrl_pkg::word_t        ramload;
  mem_ctrl_pkg::ramstate_t    ramstate;

  coherence_fsm u_fsm (
    .CLK           (CLK),
    .nRST          (nRST),
    .halted        (halted),
    .flushed       (flushed),
    .evict         (evict),
    .dREN          (dREN),
    .dWEN          (dWEN),
    .iREN          (iREN),
    .daddr         (daddr),
    .cctrans       (cctrans),
    .ccwrite       (ccwrite),
    .dwait         (dwait),
    .active        (active),
    .active_core   (active_core),
    .ccdataready   (ccdataready),
    .ccmemtransfer (ccmemtransfer),
    .cc_state      (cc_state),
    .ccwait        (ccwait),
    .ccsnoopaddr   (ccsnoopaddr),
    .ccinv         (ccinv)
  );

  bus_router u_router (
    .active        (active),
    .active_core   (active_core),
    .ccdataready   (ccdataready),
    .ccmemtransfer (ccmemtransfer),
    .cc_state      (cc_state),
    .dREN          (dREN),
    .dWEN          (dWEN),
    .iREN          (iREN),
    .daddr         (daddr),
    .iaddr         (iaddr),
    .dstore        (dstore),
    .ramload       (ramload),
    .ramstate      (ramstate),
    .iwait         (iwait),
    .dwait         (dwait),
    .iload         (iload),
    .dload         (dload),
    .ramREN        (ramREN),
    .ramWEN        (ramWEN),
    .ramaddr       (ramaddr),
    .ramstore      (ramstore)
  );

  ram_model u_ram (
    .CLK      (CLK),
    .nRST     (nRST),
    .ramREN   (ramREN),
    .ramWEN   (ramWEN),
    .ramaddr  (ramaddr),
    .ramstore (ramstore),
    .ramload  (ramload),
    .ramstate (ramstate)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic CLK,
  output logic nRST
);

  localparam int HALF_NS      = 2;
  localparam int RESET_CYCLES = 16;

  initial begin
    CLK = 1'b0;
    forever #(HALF_NS) CLK = ~CLK;
  end

  // release just after an edge, like the other inputs
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    nRST = 1'b1;
  end

endmodule

// ==== verif/tb_coherent_mem.sv ====
`timescale 1ns/1ps

module tb_coherent_mem;

  logic                CLK;
  logic                nRST;
  logic [1:0]          iREN;
  logic [1:0]          dREN;
  logic [1:0]          dWEN;
  logic [1:0]          cctrans;
  logic [1:0]          ccwrite;
  logic [1:0]          halted;
  logic [1:0]          flushed;
  logic [1:0]          evict;
  logic [1:0]          iwait;
  logic [1:0]          dwait;
  logic [1:0]          ccwait;
  logic [1:0]          ccinv;
  mem_ctrl_pkg::word_t iaddr [2];
  mem_ctrl_pkg::word_t daddr [2];
  mem_ctrl_pkg::word_t dstore [2];
  mem_ctrl_pkg::word_t req_store [2];
  mem_ctrl_pkg::word_t snoop_store [2];
  mem_ctrl_pkg::word_t iload [2];
  mem_ctrl_pkg::word_t dload [2];
  mem_ctrl_pkg::word_t ccsnoopaddr [2];

  // peer copy for the current vector, 0 none 1 shared 2 modified
  logic [1:0]          peer_mode;
  mem_ctrl_pkg::word_t peer_data;

  string               op_q [$];
  logic                core_q [$];
  mem_ctrl_pkg::word_t addr_q [$];
  mem_ctrl_pkg::word_t data_q [$];
  logic [1:0]          mode_q [$];
  mem_ctrl_pkg::word_t pdata_q [$];
  mem_ctrl_pkg::word_t exp_q [$];
  int                  limit = 0;
  int unsigned         rng_state = 6;

  tb_clock_gen clk_gen (.CLK(CLK), .nRST(nRST));

  coherent_mem_sys DUT (
    .CLK(CLK), .nRST(nRST), .iREN(iREN), .iaddr(iaddr), .dREN(dREN), .dWEN(dWEN),
    .daddr(daddr), .dstore(dstore), .cctrans(cctrans), .ccwrite(ccwrite),
    .halted(halted), .flushed(flushed), .evict(evict), .iwait(iwait), .dwait(dwait),
    .iload(iload), .dload(dload), .ccwait(ccwait), .ccsnoopaddr(ccsnoopaddr), .ccinv(ccinv)
  );

  // a snooped cache answers with its own word
  assign dstore[0] = ccwait[0] ? snoop_store[0] : req_store[0];
  assign dstore[1] = ccwait[1] ? snoop_store[1] : req_store[1];

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input mem_ctrl_pkg::word_t actual,
                             input mem_ctrl_pkg::word_t expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
      stop_run("check failed");
    end
  endtask

  task automatic next_edge();
    @(posedge CLK);
    #1;
  endtask

  task automatic start_data(input logic core, input logic wr, input mem_ctrl_pkg::word_t addr,
                            input mem_ctrl_pkg::word_t data);
    daddr[core]     = addr;
    req_store[core] = data;
    dREN[core]      = ~wr;
    dWEN[core]      = wr;
  endtask

  // counts edges from the request to the cycle its wait is low
  task automatic wait_done(input logic core, input logic inst, output int cycles,
                           output mem_ctrl_pkg::word_t load);
    logic busy;
    cycles = 0;
    busy   = 1'b1;
    while (busy) begin
      @(posedge CLK);
      cycles++;
      @(negedge CLK);
      busy = inst ? iwait[core] : dwait[core];
    end
    load = inst ? iload[core] : dload[core];
  endtask

  // data request of one core, the other core's data wait must stay high throughout
  task automatic wait_first_done(input logic core, input logic held, output int cycles,
                                 output mem_ctrl_pkg::word_t load);
    logic busy;
    cycles = 0;
    busy   = 1'b1;
    while (busy) begin
      @(posedge CLK);
      cycles++;
      @(negedge CLK);
      check_value("dwait of waiting core", 32'(dwait[held]), 32'h1);
      busy = dwait[core];
    end
    load = dload[core];
  endtask

  task automatic finish_access(input logic core);
    next_edge();
    iREN[core] = 1'b0;
    dREN[core] = 1'b0;
    dWEN[core] = 1'b0;
  endtask

  task automatic load_golden();
    int                  fd;
    int                  n;
    int                  core_i;
    string               line;
    string               op_s;
    string               peer_s;
    mem_ctrl_pkg::word_t a;
    mem_ctrl_pkg::word_t d;
    mem_ctrl_pkg::word_t p;
    mem_ctrl_pkg::word_t e;
    fd = $fopen("verif/golden_vectors.txt", "r");
    if (fd == 0) begin
      stop_run("could not open verif/golden_vectors.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%s %d %h %h %s %h %h", op_s, core_i, a, d, peer_s, p, e);
        if (n > 0 && n != 7) begin
          stop_run({"malformed golden line: ", line});
        end
        if (n == 7) begin
          op_q.push_back(op_s);
          core_q.push_back(core_i[0]);
          addr_q.push_back(a);
          data_q.push_back(d);
          mode_q.push_back(peer_s == "M" ? 2'd2 : (peer_s == "S" ? 2'd1 : 2'd0));
          pdata_q.push_back(p);
          exp_q.push_back(e);
        end
      end
    end
    $fclose(fd);
    if (op_q.size() == 0) begin
      stop_run("golden file holds no vectors");
    end
  endtask

  // peer cache model
  initial begin
    cctrans        = '0;
    ccwrite        = '0;
    snoop_store[0] = '0;
    snoop_store[1] = '0;
    forever begin
      next_edge();
      for (int k = 0; k < 2; k++) begin
        cctrans[k]     = ccwait[k] && (peer_mode != 2'd0);
        ccwrite[k]     = ccwait[k] && (peer_mode == 2'd2);
        snoop_store[k] = peer_data;
      end
    end
  end

  initial begin
    wait (limit > 0);
    repeat (limit) @(posedge CLK);
    stop_run($sformatf("controller hung: tests not done within %0d cycles", limit));
  end

  initial begin
    logic                core;
    logic                other;
    int                  cycles;
    int unsigned         gap;
    mem_ctrl_pkg::word_t load;

    iREN      = '0;
    dREN      = '0;
    dWEN      = '0;
    halted    = '0;
    flushed   = '0;
    evict     = '0;
    peer_mode = 2'd0;
    peer_data = '0;
    for (int k = 0; k < 2; k++) begin
      iaddr[k]     = '0;
      daddr[k]     = '0;
      req_store[k] = '0;
    end

    load_golden();
    limit = 16 + op_q.size() * (mem_ctrl_pkg::RAM_LAT + 10);

    wait (nRST === 1'b1);
    @(negedge CLK);
    check_value("iwait after reset", 32'(iwait), 32'h3);
    check_value("dwait after reset", 32'(dwait), 32'h3);
    check_value("ccwait after reset", 32'(ccwait), 32'h0);
    check_value("ccinv after reset", 32'(ccinv), 32'h0);
    check_value("ramREN after reset", 32'(DUT.ramREN), 32'h0);
    check_value("ramWEN after reset", 32'(DUT.ramWEN), 32'h0);
    next_edge();

    for (int v = 0; v < op_q.size(); v++) begin
      core      = core_q[v];
      other     = ~core;
      peer_mode = mode_q[v];
      peer_data = pdata_q[v];
      if (op_q[v] == "IF") begin
        iaddr[core] = addr_q[v];
        iREN[core]  = 1'b1;
        wait_done(core, 1'b1, cycles, load);
        check_value("fetch latency", 32'(cycles), 32'(mem_ctrl_pkg::RAM_LAT + 1));
        check_value("iload", load, exp_q[v]);
        finish_access(core);
      end else if (op_q[v] == "RD" || op_q[v] == "WR") begin
        start_data(core, op_q[v] == "WR", addr_q[v], data_q[v]);
        wait_done(core, 1'b0, cycles, load);
        if (op_q[v] == "WR") begin
          check_value("ccinv of peer", 32'(ccinv[other]), 32'h1);
        end else begin
          check_value("dload", load, exp_q[v]);
        end
        if (peer_mode == 2'd1) begin
          check_value("cache to cache latency", 32'(cycles), 32'd4);
          check_value("ccwait of peer", 32'(ccwait[other]), 32'h1);
          check_value("ccsnoopaddr of peer", ccsnoopaddr[other], addr_q[v]);
        end
        finish_access(core);
      end else if (op_q[v] == "PRI") begin
        // core 0 writes while core 1 reads the same word
        start_data(1'b0, 1'b1, addr_q[v], data_q[v]);
        start_data(1'b1, 1'b0, addr_q[v], '0);
        wait_first_done(1'b0, 1'b1, cycles, load);
        check_value("ccinv of core 1", 32'(ccinv[1]), 32'h1);
        finish_access(1'b0);
        wait_done(1'b1, 1'b0, cycles, load);
        check_value("dload of core 1", load, exp_q[v]);
        finish_access(1'b1);
      end else if (op_q[v] == "HALT") begin
        halted[core]  = 1'b1;
        flushed[core] = 1'b0;
        start_data(other, 1'b0, addr_q[v], '0);
        // longer than one complete miss
        repeat (mem_ctrl_pkg::RAM_LAT + 6) begin
          @(negedge CLK);
          check_value("dwait during flush", 32'(dwait[other]), 32'h1);
        end
        next_edge();
        flushed[core] = 1'b1;
        wait_done(other, 1'b0, cycles, load);
        check_value("dload after flush", load, exp_q[v]);
        finish_access(other);
        next_edge();
        halted[core]  = 1'b0;
        flushed[core] = 1'b0;
      end else begin
        stop_run({"unknown operation in golden file: ", op_q[v]});
      end
      rng_state = lcg_next(rng_state);
      gap       = (rng_state >> 16) % 4;
      repeat (1 + gap) next_edge();
    end

    $display("** PASS **");
    $finish;
  end

endmodule

// ==== files.f ====
rtl/mem_ctrl_pkg.sv
rtl/coherence_fsm.sv
rtl/ram_model.sv
rtl/bus_router.sv
rtl/coherent_mem_sys.sv
verif/tb_clock_gen.sv
verif/tb_coherent_mem.sv

// ==== Makefile ====
# Verilator build for the coherent memory system

VERILATOR ?= verilator
TOP       ?= tb_coherent_mem
RTL_TOP   ?= coherent_mem_sys
SRC_LIST  ?= files.f
GOLDEN    ?= verif/golden_vectors.txt
BUILD_DIR ?= obj_dir
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(SRC_LIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SRC_LIST)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(SRC_LIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR)

# the testbench reads the golden file relative to the project root
sim: $(BUILD_DIR)/V$(TOP) $(GOLDEN)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/golden_vectors.txt ====
# op core addr data peer peer_data expected  (hex except core)
# peer N none, S shared, M modified; PRI core 0 writes, core 1 reads; HALT core is halted
WR   0 00000010 deadbeef N 00000000 00000000
IF   1 00000010 00000000 N 00000000 deadbeef
RD   0 00000020 00000000 N 00000000 00000000
WR   1 00000020 12345678 N 00000000 00000000
RD   0 00000020 00000000 N 00000000 12345678
RD   1 00000030 00000000 S cafef00d cafef00d
RD   0 00000030 00000000 N 00000000 00000000
RD   0 00000040 00000000 M a5a5a5a5 a5a5a5a5
RD   1 00000040 00000000 N 00000000 a5a5a5a5
IF   0 00000040 00000000 N 00000000 a5a5a5a5
PRI  0 00000050 0badf00d N 00000000 0badf00d
WR   0 000003fc 11112222 N 00000000 00000000
IF   0 000003fc 00000000 N 00000000 11112222
RD   1 00000060 00000000 S 77778888 77778888
RD   1 00000070 00000000 M 5555aaaa 5555aaaa
RD   0 00000070 00000000 N 00000000 5555aaaa
HALT 1 00000050 00000000 N 00000000 0badf00d
RD   1 00000050 00000000 N 00000000 0badf00d
